/* test/simf_alu_trace.txt */
# name ctrl src1 src2 exec vcc_in, then expected vgpr_wr data vcc (all hex but the name)
# ctrl is fmt[31:24] reserved[23:12] opcode[11:0]; data is ignored when vgpr_wr is 0
vopc_f       08000000 bf800000 40000000 1 1 0 00000000 0
vopc_lt      08000001 bf800000 40000000 1 0 0 00000000 1
vopc_eq      08000002 bf800000 40000000 1 1 0 00000000 0
vopc_le      08000003 bf800000 40000000 1 0 0 00000000 1
vopc_gt      08000004 bf800000 40000000 1 1 0 00000000 0
vopc_lg      08000005 bf800000 40000000 1 0 0 00000000 1
vopc_ge      08000006 bf800000 40000000 1 1 0 00000000 0
vopc_nge     08000009 bf800000 40000000 1 0 0 00000000 1
vopc_nlg     0800000a bf800000 40000000 1 1 0 00000000 0
vopc_ngt     0800000b bf800000 40000000 1 0 0 00000000 1
vopc_nle     0800000c bf800000 40000000 1 1 0 00000000 0
vopc_neq     0800000d bf800000 40000000 1 0 0 00000000 1
vopc_nlt     0800000e bf800000 40000000 1 1 0 00000000 0
vopc_tru     0800000f bf800000 40000000 1 0 0 00000000 1
vop3a_f      10000000 bf800000 c0000000 1 1 0 00000000 0
vop3a_lt     10000001 bf800000 c0000000 1 1 0 00000000 0
vop3a_eq     10000002 bf800000 c0000000 1 1 0 00000000 0
vop3a_le     10000003 bf800000 c0000000 1 1 0 00000000 0
vop3a_gt     10000004 bf800000 c0000000 1 0 0 00000000 1
vop3a_lg     10000005 bf800000 c0000000 1 0 0 00000000 1
vop3a_ge     10000006 bf800000 c0000000 1 0 0 00000000 1
vop3a_nge    10000009 bf800000 c0000000 1 1 0 00000000 0
vop3a_nlg    1000000a bf800000 c0000000 1 1 0 00000000 0
vop3a_ngt    1000000b bf800000 c0000000 1 1 0 00000000 0
vop3a_nle    1000000c bf800000 c0000000 1 0 0 00000000 1
vop3a_neq    1000000d bf800000 c0000000 1 0 0 00000000 1
vop3a_nlt    1000000e bf800000 c0000000 1 0 0 00000000 1
vop3a_tru    1000000f bf800000 c0000000 1 0 0 00000000 1
eq_one       08000002 3f800000 3f800000 1 0 0 00000000 1
eq_zeros     08000002 00000000 80000000 1 1 0 00000000 0
neq_zeros    1000000d 80000000 00000000 1 0 0 00000000 1
lt_zeros     08000001 80000000 00000000 1 0 0 00000000 1
ge_equal     10000006 c0000000 c0000000 1 0 0 00000000 1
nlg_equal    0800000a 40000000 40000000 1 0 0 00000000 1
lt_nan       08000001 3f800000 7fc00000 1 0 0 00000000 1
gt_neg_nan   10000004 bf800000 ffc00000 1 0 0 00000000 1
max_pos      02000010 3f800000 40000000 1 1 1 40000000 1
max_mixed    02000010 c0000000 3f800000 1 0 1 3f800000 0
max_neg      02000010 bf800000 c0000000 1 1 1 bf800000 1
max_tie      02000010 40000000 40000000 1 0 1 40000000 0
max_zeros    02000010 80000000 00000000 1 1 1 00000000 1
max_nan      02000010 7fc00000 3f800000 1 0 1 7fc00000 0
exec0_cmp    0800000f 3f800000 40000000 0 0 0 00000000 0
exec0_cmp_f  10000000 3f800000 40000000 0 1 0 00000000 1
exec0_max    02000010 3f800000 40000000 0 1 0 00000000 1
unk_code7    08000007 3f800000 40000000 1 1 0 00000000 1
unk_code8    10000008 3f800000 40000000 1 0 0 00000000 0
unk_vop2_cmp 02000001 bf800000 40000000 1 1 0 00000000 1
unk_vopc_max 08000010 3f800000 40000000 1 0 0 00000000 0
unk_fmt      04000010 3f800000 40000000 1 1 0 00000000 1
unk_vop2_opc 02000011 3f800000 40000000 1 0 0 00000000 0

/* verilog.f */
logic/alu_pkg.sv
logic/simf_alu_decode.sv
logic/simf_alu_compare.sv
logic/simf_alu_writeback.sv
logic/simf_alu.sv
test/tb_simf_alu.sv

/* Makefile */
# Verilator simulation of the compare and max ALU lane

VERILATOR ?= verilator
TOP       ?= tb_simf_alu
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= === PASS ===

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/tb_simf_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_simf_alu;

   localparam int CLK_PERIOD = 100;

   logic                       clk;
   logic                       arst_n;
   logic                       start;
   alu_pkg::alu_req_t          req;
   wire                        done;
   wire                        vgpr_wr;
   wire [alu_pkg::DATA_W-1:0]  vgpr_data;
   wire                        vcc;

   string                      name_q[$];
   alu_pkg::alu_req_t          req_q[$];
   logic                       exp_wr_q[$];
   logic [alu_pkg::DATA_W-1:0] exp_data_q[$];
   logic                       exp_vcc_q[$];
   int                         pend_q[$]; // Issued ops awaiting done

   int                         n_tests = 0;
   int                         n_pass = 0;
   int                         n_fail = 0;
   int                         n_err = 0;
   logic                       trace_loaded = 1'b0;
   logic [2:0]                 start_hist; // start_i seen at the last three edges
   integer                     seed = 81250;

   simf_alu u_dut
     (
      .clk         (clk),
      .arst_n_i    (arst_n),
      .start_i     (start),
      .req_i       (req),
      .done_o      (done),
      .vgpr_wr_o   (vgpr_wr),
      .vgpr_data_o (vgpr_data),
      .vcc_o       (vcc)
      );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic read_trace();
      int                         fd;
      int                         cnt;
      string                      line;
      string                      name;
      logic [31:0]                ctrl;
      logic [31:0]                src1;
      logic [31:0]                src2;
      logic [31:0]                exec;
      logic [31:0]                vcc_in;
      logic [31:0]                exp_wr;
      logic [alu_pkg::DATA_W-1:0] exp_data;
      logic [31:0]                exp_vcc;
      alu_pkg::alu_req_t          rq;
      fd = $fopen("test/simf_alu_trace.txt", "r");
      if (fd == 0)
      begin
         $display("ERROR: cannot open test/simf_alu_trace.txt");
      end
      else
      begin
         while ($fgets(line, fd) != 0)
         begin
            if ((line.len() > 1) && (line.getc(0) != "#"))
            begin
               cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h", name, ctrl, src1, src2,
                             exec, vcc_in, exp_wr, exp_data, exp_vcc);
               if (cnt != 9)
               begin
                  $display("ERROR: trace line could not be parsed: %s", line);
                  n_err++;
               end
               else
               begin
                  rq.ctrl   = ctrl;
                  rq.src1   = src1;
                  rq.src2   = src2;
                  rq.exec   = exec[0];
                  rq.vcc_in = vcc_in[0];
                  name_q.push_back(name);
                  req_q.push_back(rq);
                  exp_wr_q.push_back(exp_wr[0]);
                  exp_data_q.push_back(exp_data);
                  exp_vcc_q.push_back(exp_vcc[0]);
               end
            end
         end
         $fclose(fd);
      end
      n_tests = name_q.size();
   endtask

   // Random idle gap of 0..3 cycles after each operation
   task automatic issue_ops();
      int gap;
      for (int i = 0; i < n_tests; i++)
      begin
         @(posedge clk);
         start <= 1'b1;
         req   <= req_q[i];
         pend_q.push_back(i);
         gap = $unsigned($random(seed)) % 4;
         repeat (gap)
         begin
            @(posedge clk);
            start <= 1'b0;
         end
      end
      @(posedge clk);
      start <= 1'b0;
   endtask

   always @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         start_hist <= 3'b000;
      else
         start_hist <= {start_hist[1:0], start};
   end

   always @(negedge clk)
   begin : check_outputs
      int   idx;
      logic bad;
      if (arst_n)
      begin
         if (done !== start_hist[2]) // Two cycles after the sampling edge
         begin
            $display("CHECK FAILED latency: expected done_o=%0b actual=%0b at %0t",
                     start_hist[2], done, $time);
            n_err++;
         end
         if (!done && (vgpr_wr !== 1'b0))
         begin
            $display("CHECK FAILED idle_write: expected vgpr_wr_o=0 actual=%0b at %0t",
                     vgpr_wr, $time);
            n_err++;
         end
         if (done)
         begin
            if (pend_q.size() == 0)
            begin
               $display("ERROR: done_o pulsed with no operation outstanding at %0t", $time);
               n_err++;
            end
            else
            begin
               idx = pend_q.pop_front();
               bad = 1'b0;
               if (vgpr_wr !== exp_wr_q[idx])
                  bad = 1'b1;
               if (vcc !== exp_vcc_q[idx])
                  bad = 1'b1;
               if (exp_wr_q[idx] && (vgpr_data !== exp_data_q[idx]))
                  bad = 1'b1;
               if (bad)
               begin
                  $write("CHECK FAILED %s: expected wr=%0b data=%08h vcc=%0b,",
                         name_q[idx], exp_wr_q[idx], exp_data_q[idx], exp_vcc_q[idx]);
                  $display(" actual wr=%0b data=%08h vcc=%0b", vgpr_wr, vgpr_data, vcc);
                  n_fail++;
               end
               else
               begin
                  $display("[ok] %s wr=%0b data=%08h vcc=%0b",
                           name_q[idx], vgpr_wr, vgpr_data, vcc);
                  n_pass++;
               end
            end
         end
      end
   end

   // Six cycles per operation plus margin
   initial
   begin
      wait (trace_loaded);
      repeat (n_tests * 6 + 20) @(posedge clk);
      $display("ERROR: timeout, only %0d of %0d results seen", n_pass + n_fail, n_tests);
      $display("=== FAIL ===");
      $finish;
   end

   initial
   begin
      arst_n = 1'b0;
      start  = 1'b0;
      req    = '0;
      read_trace();
      trace_loaded = 1'b1;
      if (n_tests == 0)
      begin
         $display("ERROR: no operations read from the trace file");
         $display("=== FAIL ===");
      end
      else
      begin
         repeat (2) @(posedge clk);
         arst_n <= 1'b1;
         repeat (3) @(posedge clk); // Outputs must stay quiet here
         issue_ops();
         while ((n_pass + n_fail) < n_tests)
            @(posedge clk);
         repeat (4) @(posedge clk); // Catch stray done pulses
         $display("%0d tests: %0d passed, %0d failed, %0d other errors",
                  n_tests, n_pass, n_fail, n_err);
         if ((n_fail == 0) && (n_err == 0))
            $display("=== PASS ===");
         else
            $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* logic/simf_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module simf_alu
  (
   input  wire                       clk,
   input  wire                       arst_n_i,
   input  wire logic                 start_i,
   input  wire alu_pkg::alu_req_t    req_i,
   output wire                       done_o,
   output wire                       vgpr_wr_o,
   output wire [alu_pkg::DATA_W-1:0] vgpr_data_o,
   output wire                       vcc_o
   );

   wire alu_pkg::alu_dec_t dec; // Decode to compare
   wire alu_pkg::alu_res_t res; // Compare to writeback

   simf_alu_decode u_decode
     (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .start_i  (start_i),
      .req_i    (req_i),
      .dec_o    (dec)
      );

   simf_alu_compare u_compare
     (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .dec_i    (dec),
      .res_o    (res)
      );

   simf_alu_writeback u_writeback
     (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .res_i       (res),
      .done_o      (done_o),
      .vgpr_wr_o   (vgpr_wr_o),
      .vgpr_data_o (vgpr_data_o),
      .vcc_o       (vcc_o)
      );

endmodule

`default_nettype wire

/* logic/simf_alu_writeback.sv */
`timescale 1ns/1ns
`default_nettype none

module simf_alu_writeback
  (
   input  wire                       clk,
   input  wire                       arst_n_i,
   input  wire alu_pkg::alu_res_t    res_i,
   output logic                      done_o,
   output logic                      vgpr_wr_o,
   output logic [alu_pkg::DATA_W-1:0] vgpr_data_o,
   output logic                      vcc_o
   );

   logic wr_en;
   logic vcc_nxt;

   // Lane disabled keeps VCC and suppresses the write
   assign wr_en   = res_i.exec & res_i.vgpr_wr;
   assign vcc_nxt = res_i.exec ? res_i.vcc : res_i.vcc_in;

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         done_o      <= 1'b0;
         vgpr_wr_o   <= 1'b0;
         vgpr_data_o <= '0;
         vcc_o       <= 1'b0;
      end
      else
      begin
         done_o    <= res_i.valid;
         vgpr_wr_o <= res_i.valid & wr_en;
         if (res_i.valid)
         begin
            vgpr_data_o <= res_i.data;
            vcc_o       <= vcc_nxt; // Held between ops
         end
      end
   end

endmodule

`default_nettype wire

/* logic/simf_alu_compare.sv */
`timescale 1ns/1ns
`default_nettype none

module simf_alu_compare
  (
   input  wire                clk,
   input  wire                arst_n_i,
   input  wire alu_pkg::alu_dec_t dec_i,
   output alu_pkg::alu_res_t  res_o
   );

   logic [alu_pkg::DATA_W-1:0] key1;
   logic [alu_pkg::DATA_W-1:0] key2;
   logic [alu_pkg::DATA_W-1:0] max_data;
   logic                       lt;
   logic                       eq;
   logic                       gt;
   logic                       cmp_bit;

   // Sign-magnitude float mapped onto unsigned order
   function automatic logic [alu_pkg::DATA_W-1:0] order_key
     (input logic [alu_pkg::DATA_W-1:0] x);
      if (x[alu_pkg::DATA_W-1])
         order_key = ~x;
      else
         order_key = {1'b1, x[alu_pkg::DATA_W-2:0]};
   endfunction

   assign key1 = order_key(dec_i.src1);
   assign key2 = order_key(dec_i.src2);

   assign lt = (key1 < key2);
   assign eq = (key1 == key2); // -0 and +0 differ
   assign gt = (key1 > key2);

   assign max_data = (gt || eq) ? dec_i.src1 : dec_i.src2; // Tie keeps src1

   always_comb
   begin
      case (dec_i.code)
         alu_pkg::CMP_F   : cmp_bit = 1'b0;
         alu_pkg::CMP_LT  : cmp_bit = lt;
         alu_pkg::CMP_EQ  : cmp_bit = eq;
         alu_pkg::CMP_LE  : cmp_bit = lt | eq;
         alu_pkg::CMP_GT  : cmp_bit = gt;
         alu_pkg::CMP_LG  : cmp_bit = lt | gt;
         alu_pkg::CMP_GE  : cmp_bit = gt | eq;
         alu_pkg::CMP_NGE : cmp_bit = ~(gt | eq);
         alu_pkg::CMP_NLG : cmp_bit = ~(lt | gt);
         alu_pkg::CMP_NGT : cmp_bit = ~gt;
         alu_pkg::CMP_NLE : cmp_bit = ~(lt | eq);
         alu_pkg::CMP_NEQ : cmp_bit = ~eq;
         alu_pkg::CMP_NLT : cmp_bit = ~lt;
         alu_pkg::CMP_TRU : cmp_bit = 1'b1;
         default          : cmp_bit = 1'b0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         res_o <= '0;
      end
      else
      begin
         res_o.valid   <= dec_i.valid;
         res_o.vgpr_wr <= (dec_i.kind == alu_pkg::KIND_MAX);
         res_o.data    <= max_data; // Only meaningful for max
         res_o.vcc     <= (dec_i.kind == alu_pkg::KIND_CMP) ? cmp_bit : dec_i.vcc_in;
         res_o.vcc_in  <= dec_i.vcc_in;
         res_o.exec    <= dec_i.exec;
      end
   end

endmodule

`default_nettype wire

/* logic/simf_alu_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module simf_alu_decode
  (
   input  wire                clk,
   input  wire                arst_n_i,
   input  wire logic          start_i,
   input  wire alu_pkg::alu_req_t req_i,
   output alu_pkg::alu_dec_t  dec_o
   );

   alu_pkg::alu_kind_t kind;
   alu_pkg::cmp_code_t code;
   logic               is_cmp_fmt;
   logic               in_cmp_range;
   logic               code_hole;

   assign is_cmp_fmt = (req_i.ctrl.fmt == alu_pkg::FMT_VOPC) ||
                       (req_i.ctrl.fmt == alu_pkg::FMT_VOP3A);

   // Opcodes 0x000..0x00F
   assign in_cmp_range = (req_i.ctrl.opcode[alu_pkg::OPC_W-1:4] ==
                          alu_pkg::OPC_CMP_BASE[alu_pkg::OPC_W-1:4]);

   assign code_hole = (req_i.ctrl.opcode[3:0] == 4'd7) ||
                      (req_i.ctrl.opcode[3:0] == 4'd8); // Not defined

   always_comb
   begin
      kind = alu_pkg::KIND_NONE;
      code = alu_pkg::CMP_F;
      if ((req_i.ctrl.fmt == alu_pkg::FMT_VOP2) &&
          (req_i.ctrl.opcode == alu_pkg::OPC_MAX_F32))
      begin
         kind = alu_pkg::KIND_MAX;
      end
      else if (is_cmp_fmt && in_cmp_range && !code_hole)
      begin
         kind = alu_pkg::KIND_CMP;
         code = alu_pkg::cmp_code_t'(req_i.ctrl.opcode[3:0]);
      end
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         dec_o <= '0;
      end
      else
      begin
         dec_o.valid  <= start_i;
         dec_o.kind   <= kind;
         dec_o.code   <= code;
         dec_o.src1   <= req_i.src1;
         dec_o.src2   <= req_i.src2;
         dec_o.exec   <= req_i.exec; // Masked at writeback
         dec_o.vcc_in <= req_i.vcc_in;
      end
   end

endmodule

`default_nettype wire

/* logic/alu_pkg.sv */
`default_nettype none

package alu_pkg;

   localparam int DATA_W = 32;
   localparam int FMT_W  = 8;
   localparam int OPC_W  = 12;
   localparam int RSVD_W = 32 - FMT_W - OPC_W;

   // Instruction formats seen on the control word
   localparam logic [FMT_W-1:0] FMT_VOP2  = 8'h02;
   localparam logic [FMT_W-1:0] FMT_VOPC  = 8'h08;
   localparam logic [FMT_W-1:0] FMT_VOP3A = 8'h10;

   localparam logic [OPC_W-1:0] OPC_MAX_F32  = 12'h010; // VOP2 only
   localparam logic [OPC_W-1:0] OPC_CMP_BASE = 12'h000; // Low nibble is the code

   typedef enum logic [3:0] {
      CMP_F   = 4'd0,
      CMP_LT  = 4'd1,
      CMP_EQ  = 4'd2,
      CMP_LE  = 4'd3,
      CMP_GT  = 4'd4,
      CMP_LG  = 4'd5,
      CMP_GE  = 4'd6,
      CMP_NGE = 4'd9,
      CMP_NLG = 4'd10,
      CMP_NGT = 4'd11,
      CMP_NLE = 4'd12,
      CMP_NEQ = 4'd13,
      CMP_NLT = 4'd14,
      CMP_TRU = 4'd15
   } cmp_code_t;

   typedef enum logic [1:0] {
      KIND_NONE,
      KIND_CMP,
      KIND_MAX
   } alu_kind_t;

   typedef struct packed {
      logic [FMT_W-1:0]  fmt;
      logic [RSVD_W-1:0] rsvd;
      logic [OPC_W-1:0]  opcode;
   } alu_ctrl_t;

   typedef struct packed {
      alu_ctrl_t         ctrl;
      logic [DATA_W-1:0] src1;
      logic [DATA_W-1:0] src2;
      logic              exec;
      logic              vcc_in;
   } alu_req_t;

   typedef struct packed {
      logic              valid;
      alu_kind_t         kind;
      cmp_code_t         code;
      logic [DATA_W-1:0] src1;
      logic [DATA_W-1:0] src2;
      logic              exec;
      logic              vcc_in;
   } alu_dec_t;

   typedef struct packed {
      logic              valid;
      logic              vgpr_wr;
      logic [DATA_W-1:0] data;
      logic              vcc;
      logic              vcc_in; // Lane VCC before the op
      logic              exec;
   } alu_res_t;

endpackage

`default_nettype wire
